//--- gather_pkg.sv
// ---------------------------------------------------------
// widths, lane count, lane depth and the entry and bank
// write types shared by the gather buffer
// ---------------------------------------------------------

package gather_pkg;

    // width of one result word
    localparam int DATA_WIDTH = 16;

    // input lanes and memory banks, one bank per lane index
    localparam int NUM_LANES = 8;

    // width of a bank index
    localparam int BRANCH_WIDTH = 3;

    // entries per lane FIFO
    // small so the producer sees back-pressure early
    localparam int LANE_DEPTH = 4;

    // a lane or bank number
    typedef logic [BRANCH_WIDTH-1:0] lane_index_t;

    // one lane result and the bank it is headed for
    typedef struct packed {
        lane_index_t           branch;
        logic [DATA_WIDTH-1:0] data;
    } lane_entry_t;

    // all lanes of one input beat, lane 0 in the low bits
    typedef lane_entry_t [NUM_LANES-1:0] lane_bus_t;

    // one bit per lane or per bank
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    // word broadcast to every bank, valid picks the bank that writes
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        lane_mask_t            valid;
    } bank_write_t;

endpackage : gather_pkg

//--- lane_fifo.sv
// ---------------------------------------------------------
// single-lane FIFO of lane entries, read-first
// ---------------------------------------------------------

module lane_fifo #(
    parameter int DEPTH = gather_pkg::LANE_DEPTH
) (
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_push,
    input  gather_pkg::lane_entry_t i_entry,
    output logic                    o_ready,
    input  logic                    i_pop,
    output logic                    o_valid,
    output gather_pkg::lane_entry_t o_entry
);

    import gather_pkg::*;

    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(DEPTH + 1);

    lane_entry_t        storage [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] count;

    // push is qualified by the shared ready at the top level,
    // pop only ever comes for a lane that shows valid
    assign o_ready = (count < COUNT_W'(DEPTH));
    assign o_valid = (count != '0);
    assign o_entry = storage[rd_ptr];

    always_ff @(posedge i_clock) begin
        if (i_push) begin
            storage[wr_ptr] <= i_entry;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                if (wr_ptr == PTR_W'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (i_pop) begin
                if (rd_ptr == PTR_W'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // simultaneous push and pop leaves the occupancy alone
            case ({i_push, i_pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule : lane_fifo

//--- rotating_arbiter.sv
// ---------------------------------------------------------
// round-robin lane arbiter, one grant per cycle
// ---------------------------------------------------------

module rotating_arbiter (
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  gather_pkg::lane_mask_t  i_lane_valid,
    input  gather_pkg::lane_bus_t   i_lane_entry,
    output gather_pkg::lane_mask_t  o_lane_pop,
    output logic                    o_grant_valid,
    output gather_pkg::lane_entry_t o_grant_entry
);

    import gather_pkg::*;

    // lane with highest priority this cycle
    lane_index_t prio_ptr;
    lane_index_t next_ptr;

    lane_index_t grant_lane;
    logic        grant_found;

    // lane number offset from base, wrapping after the last lane
    function automatic lane_index_t wrap_lane(input lane_index_t base, input int offset);
        int sum;
        sum = int'(base) + offset;
        return lane_index_t'(sum % NUM_LANES);
    endfunction

    // search from the pointer upward and take the first lane with an entry
    always_comb begin
        grant_found = 1'b0;
        grant_lane  = prio_ptr;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (!grant_found && i_lane_valid[wrap_lane(prio_ptr, i)]) begin
                grant_found = 1'b1;
                grant_lane  = wrap_lane(prio_ptr, i);
            end
        end
    end

    assign next_ptr = wrap_lane(grant_lane, 1);

    assign o_grant_valid = grant_found;
    assign o_grant_entry = i_lane_entry[grant_lane];
    assign o_lane_pop    = grant_found ? (lane_mask_t'(1) << grant_lane) : '0;

    // priority moves past the granted lane, holds when all lanes are empty
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            prio_ptr <= '0;
        end else if (grant_found) begin
            prio_ptr <= next_ptr;
        end
    end

endmodule : rotating_arbiter

//--- bank_write_router.sv
// ---------------------------------------------------------
// registered bank write, broadcast word and one-hot valid
// ---------------------------------------------------------

module bank_write_router (
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_grant_valid,
    input  gather_pkg::lane_entry_t i_grant_entry,
    output gather_pkg::bank_write_t o_write
);

    import gather_pkg::*;

    lane_mask_t bank_valid;

    // only the destination bank sees valid
    assign bank_valid = i_grant_valid ? (lane_mask_t'(1) << i_grant_entry.branch) : '0;

    always_ff @(posedge i_clock) begin
        // every bank gets the word, valid decides who writes it
        o_write.data <= i_grant_entry.data;
        if (i_reset) begin
            o_write.valid <= '0;
        end else begin
            o_write.valid <= bank_valid;
        end
    end

endmodule : bank_write_router

//--- miso_fifo_8.sv
// ---------------------------------------------------------
// eight-lane gather buffer: lane FIFOs, arbiter, bank router
// ---------------------------------------------------------

module miso_fifo_8 (
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  gather_pkg::lane_bus_t   i_lanes,
    input  logic                    i_valid,
    output logic                    o_ready,
    output gather_pkg::bank_write_t o_write
);

    import gather_pkg::*;

    logic        push;
    lane_mask_t  lane_ready;
    lane_mask_t  lane_valid;
    lane_mask_t  lane_pop;
    lane_bus_t   lane_head;

    logic        grant_valid;
    lane_entry_t grant_entry;

    // a beat goes in only when every lane has room
    assign o_ready = &lane_ready;
    assign push    = i_valid & o_ready;

    generate
        for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane
            lane_fifo #(
                .DEPTH(LANE_DEPTH)
            ) u_lane_fifo (
                .i_clock (i_clock),
                .i_reset (i_reset),
                .i_push  (push),
                .i_entry (i_lanes[lane]),
                .o_ready (lane_ready[lane]),
                .i_pop   (lane_pop[lane]),
                .o_valid (lane_valid[lane]),
                .o_entry (lane_head[lane])
            );
        end
    endgenerate

    rotating_arbiter u_arbiter (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_lane_valid  (lane_valid),
        .i_lane_entry  (lane_head),
        .o_lane_pop    (lane_pop),
        .o_grant_valid (grant_valid),
        .o_grant_entry (grant_entry)
    );

    bank_write_router u_router (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_grant_valid (grant_valid),
        .i_grant_entry (grant_entry),
        .o_write       (o_write)
    );

endmodule : miso_fifo_8

//--- tb_miso_fifo_8.sv
// ----------------------------------------------------------
// testbench for the gather buffer: file driven beats, ordered
// reference queue, bank write and back-pressure checks
// ----------------------------------------------------------

module tb_miso_fifo_8;

    timeunit 1ns;
    timeprecision 100ps;

    import gather_pkg::*;

    logic        i_clock;
    logic        i_reset;
    lane_bus_t   i_lanes;
    logic        i_valid;
    logic        o_ready;
    bank_write_t o_write;

    // entries in the order the banks should see them
    lane_entry_t expected_q[$];

    // one entry per line of the test file
    string test_names[$];
    int    test_beats[$];
    int    test_gaps[$];
    int    test_drains[$];

    string       cur_test = "after_reset";
    logic [31:0] rng_state = 32'h3810;
    int          stall_cycles = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    miso_fifo_8 u_dut (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_lanes (i_lanes),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .o_write (o_write)
    );

    initial begin
        i_clock = 1'b0;
        forever begin
            #2 i_clock = ~i_clock;
        end
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in test %s, %s: expected %0h, actual %0h",
                     cur_test, what, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // upper half of each draw is the word, bits 15:13 the bank
    function automatic lane_bus_t next_beat();
        lane_bus_t beat;
        for (int lane = 0; lane < NUM_LANES; lane++) begin
            rng_state         = lcg_next(rng_state);
            beat[lane].data   = rng_state[31:16];
            beat[lane].branch = rng_state[15:13];
        end
        return beat;
    endfunction

    task automatic read_tests();
        int    fd;
        int    status;
        string line;
        string name;
        int    beats;
        int    gap;
        int    drain;
        fd = $fopen("miso_fifo_8_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file miso_fifo_8_tests.txt");
            abort_run();
        end else begin
            while (!$feof(fd)) begin
                status = $fgets(line, fd);
                if (status != 0 && line.len() > 0 && line.getc(0) != "#") begin
                    status = $sscanf(line, "%s %d %d %d", name, beats, gap, drain);
                    if (status == 4) begin
                        test_names.push_back(name);
                        test_beats.push_back(beats);
                        test_gaps.push_back(gap);
                        test_drains.push_back(drain);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_beat(input lane_bus_t beat);
        logic taken;
        taken   = 1'b0;
        i_lanes = beat;
        i_valid = 1'b1;
        while (!taken) begin
            // ready only moves on rising edges, so it holds until the next one
            taken = o_ready;
            @(negedge i_clock);
        end
        i_valid = 1'b0;
    endtask

    task automatic drain_and_settle();
        while (expected_q.size() != 0) begin
            @(negedge i_clock);
        end
        // any write in this window has no entry left and stops the run
        repeat (10) @(negedge i_clock);
        check_value("ready after drain", 32'd1, 32'(o_ready));
    endtask

    // bank write check first, then record a beat taken at this edge
    always @(posedge i_clock) begin : monitor
        lane_entry_t exp_entry;
        if (!i_reset) begin
            if (o_write.valid != '0) begin
                if (expected_q.size() == 0) begin
                    $display("Bank write with valid %0h arrived with no entry pending in test %s",
                             o_write.valid, cur_test);
                    abort_run();
                end else begin
                    exp_entry = expected_q.pop_front();
                    check_value("bank data", 32'(exp_entry.data), 32'(o_write.data));
                    check_value("bank valid", 32'd1 << exp_entry.branch, 32'(o_write.valid));
                end
            end
            if (i_valid && o_ready) begin
                for (int lane = 0; lane < NUM_LANES; lane++) begin
                    expected_q.push_back(i_lanes[lane]);
                end
            end
            if (i_valid && !o_ready) begin
                stall_cycles++;
            end
        end
    end

    always @(posedge i_clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run went past %0d cycles in test %s",
                     cycle_limit, cur_test);
            abort_run();
        end
    end

    initial begin : main_seq
        int        total_beats;
        int        total_gaps;
        lane_bus_t beat;
        i_reset = 1'b1;
        i_valid = 1'b0;
        i_lanes = '0;
        read_tests();
        if (test_names.size() == 0) begin
            $display("The test file holds no tests");
            abort_run();
        end
        total_beats = 0;
        total_gaps  = 0;
        foreach (test_beats[t]) begin
            total_beats += test_beats[t];
            total_gaps  += test_beats[t] * test_gaps[t];
        end
        cycle_limit = total_beats * 16 + total_gaps + 100;

        repeat (2) @(posedge i_clock);
        @(negedge i_clock);
        i_reset = 1'b0;
        @(negedge i_clock);
        check_value("valid after reset", 32'd0, 32'(o_write.valid));
        check_value("ready after reset", 32'd1, 32'(o_ready));

        foreach (test_names[t]) begin
            cur_test     = test_names[t];
            stall_cycles = 0;
            for (int b = 0; b < test_beats[t]; b++) begin
                beat = next_beat();
                send_beat(beat);
                repeat (test_gaps[t]) @(negedge i_clock);
            end
            // four entries per lane against one grant per cycle must fill a lane
            if (test_gaps[t] == 0 && test_beats[t] > LANE_DEPTH + 1) begin
                check_value("ready fell during burst", 32'd1, 32'(stall_cycles > 0));
            end
            if (test_drains[t] != 0) begin
                drain_and_settle();
            end
        end
        drain_and_settle();
        $display("TEST PASSED");
        $finish;
    end

endmodule : tb_miso_fifo_8

//--- miso_fifo_8.f
gather_pkg.sv
lane_fifo.sv
rotating_arbiter.sv
bank_write_router.sv
miso_fifo_8.sv
tb_miso_fifo_8.sv

//--- run_sim.sh
#!/bin/sh
# build the gather buffer testbench with Verilator and run it
# the exit status is nonzero when the build or the run fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/100ps \
    --top-module tb_miso_fifo_8 \
    -f miso_fifo_8.f \
    -o sim_miso_fifo_8
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/sim_miso_fifo_8
run_status=$?
if [ $run_status -ne 0 ]; then
    echo "simulation failed with status $run_status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0

//--- miso_fifo_8_tests.txt
# columns: test name, beats, idle cycles after each beat, drain flag
# drain flag 1 waits for all writes and 10 quiet cycles before the next test
single_beat 1 0 1
two_beats_nogap 2 0 1
three_beats_nogap 3 0 1
burst_4_nogap 4 0 1
burst_5_nogap 5 0 1
burst_6_nogap 6 0 1
burst_8_nogap 8 0 1
burst_12_nogap 12 0 1
burst_16_nogap 16 0 1
burst_24_nogap 24 0 1
gap_1_x6 6 1 1
gap_2_x6 6 2 1
gap_3_x6 6 3 1
gap_4_x6 6 4 1
gap_5_x6 6 5 1
gap_6_x6 6 6 1
gap_7_x6 6 7 1
gap_8_x6 6 8 1
gap_9_x4 4 9 1
gap_11_x3 3 11 1
chain_gap_1 5 1 0
chain_gap_3 5 3 0
chain_nogap 7 0 0
chain_gap_2 4 2 1
chain_gap_5 3 5 0
chain_gap_6 6 6 0
chain_burst 9 0 1
mixed_gap_1_x10 10 1 1
mixed_gap_2_x10 10 2 1
mixed_gap_3_x10 10 3 1
mixed_gap_5_x8 8 5 1
long_nogap 32 0 1
long_gap_1 20 1 1
long_gap_4 16 4 1
pair_gap_2 2 2 1
pair_gap_7 2 7 1
tail_nogap_a 6 0 0
tail_gap_3 4 3 0
tail_nogap_b 10 0 0
tail_gap_1 5 1 0
tail_gap_6 3 6 0
final_burst 14 0 1
final_gap_2 8 2 1
final_pair 2 0 1
